/* tb.f */
hw/core_cfg_pkg.sv
hw/core_types_pkg.sv
hw/inst_fetch.sv
hw/fetch_buffer.sv
hw/fifo_id_stage.sv
hw/inst_decode.sv
hw/alu_execute.sv
hw/writeback_regfile.sv
hw/core_frontend_top.sv
testbench/tb_imem.sv
testbench/tb_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_core -Mdir obj_dir

out=$(./obj_dir/Vtb_core)
echo "$out"

if ! grep -qx "Test OK" <<< "$out"; then
    exit 1
fi

/* testbench/tb_core.sv */
`timescale 1ns/1ps

module tb_core import core_cfg_pkg::*, core_types_pkg::*;;

    localparam int mem_words      = 1024;
    localparam int prologue_len   = 31;    // ori r1..r31 first, rf has no reset
    localparam int timeout_cycles = 2000;

    logic        clk;
    logic        rstn;
    logic        flush;
    logic [31:0] flush_pc;
    logic        rand_wait;
    logic        wb_cyc;
    logic        wb_stb;
    logic [31:0] wb_adr;
    logic        wb_ack;
    logic [31:0] wb_dat;
    logic [31:0] mem_adr;
    logic [31:0] mem_word;
    retire_t     retire;

    logic [31:0] image [mem_words];
    logic [31:0] ref_rf [32];
    logic [31:0] ref_pc;

    integer seed;
    int     errors;
    int     errors_at_start;
    int     checks;
    int     tests;
    int     n_flush;
    bit     ibar_rewrite;
    bit     timed_out;

    core_frontend_top core_frontend_top_i (
        .clk, .rstn, .flush, .flush_pc, .wb_cyc, .wb_stb, .wb_adr, .wb_ack,
        .wb_dat_i(wb_dat), .retire
    );

    tb_imem imem_i (
        .clk, .rstn, .rand_wait, .wb_cyc, .wb_stb, .wb_adr, .wb_ack, .wb_dat,
        .mem_adr, .mem_word
    );

    assign mem_word = image[mem_adr[11:2]];    // 4 KiB window, aliases above

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    function automatic logic [4:0] pick_reg(input bit dense);
        logic [31:0] r;
        r = rnd();
        return dense ? {3'd0, r[1:0]} + 5'd1 : r[4:0];    // dense uses r1..r4 only
    endfunction

    function automatic logic [31:0] rand_inst(input bit dense);
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        r  = rnd();
        rd = pick_reg(dense);
        rj = pick_reg(dense);
        rk = pick_reg(dense);
        case (r[2:0])
            3'd0:    return {op_add_w, rk, rj, rd};
            3'd1:    return {op_sub_w, rk, rj, rd};
            3'd2:    return {op_and, rk, rj, rd};
            3'd3:    return {op_or, rk, rj, rd};
            3'd4:    return {op_xor, rk, rj, rd};
            3'd5:    return {op_addi_w, r[31:20], rj, rd};
            3'd6:    return {op_andi, r[31:20], rj, rd};
            default: return {op_ori, r[31:20], rj, rd};
        endcase
    endfunction

    task automatic load_program(input bit dense, input bit with_ibar);
        int          i;
        logic [31:0] r;
        for (i = 0; i < mem_words; i++)
            image[i] = rand_inst(dense);
        for (i = 1; i < 32; i++) begin
            r = rnd();
            image[i - 1] = {op_ori, r[31:20], 5'd0, i[4:0]};
        end
        if (with_ibar) begin
            for (i = 0; i < 4; i++)
                image[40 + 30 * i] = {op_ibar, 15'd0};
        end
    endtask

    task automatic start_model();
        int i;
        ref_pc = pc_reset;
        for (i = 0; i < 32; i++)
            ref_rf[i] = '0;
    endtask

    // one instruction of the sequential reference
    task automatic model_step(output logic [31:0] pc, output logic [4:0] rd,
                              output logic [31:0] val);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        w  = image[ref_pc[11:2]];
        a  = ref_rf[w[9:5]];
        b  = ref_rf[w[14:10]];
        pc = ref_pc;
        rd = w[4:0];
        case (w[31:15])
            op_add_w: val = a + b;
            op_sub_w: val = a - b;
            op_and:   val = a & b;
            op_or:    val = a | b;
            op_xor:   val = a ^ b;
            default: begin
                case (w[31:22])
                    op_addi_w: val = a + {{20{w[21]}}, w[21:10]};
                    op_andi:   val = a & {20'd0, w[21:10]};
                    op_ori:    val = a | {20'd0, w[21:10]};
                    default: begin
                        rd  = 5'd0;    // ibar
                        val = '0;
                    end
                endcase
            end
        endcase
        if (rd != 5'd0)
            ref_rf[rd] = val;
        ref_pc = ref_pc + 32'd4;
    endtask

    task automatic handle_retire();
        logic [31:0] pc;
        logic [31:0] val;
        logic [4:0]  rd;
        logic [31:0] next_word;
        model_step(pc, rd, val);
        check("retire.pc", retire.pc, pc);
        check("retire.rd", {27'd0, retire.rd}, {27'd0, rd});
        check("retire.value", retire.value, val);
        // the word behind a barrier changes before the barrier retires
        next_word = image[pc[11:2] + 10'd1];
        if (ibar_rewrite && next_word[31:15] == op_ibar)
            image[pc[11:2] + 10'd2] = rand_inst(1'b0);
    endtask

    task automatic reset_dut(input bit check_idle);
        rstn  = 1'b0;
        flush = 1'b0;
        repeat (10) begin
            @(posedge clk);
            #1;
            if (check_idle) begin
                check("wb_cyc", {31'd0, wb_cyc}, 32'd0);
                check("wb_stb", {31'd0, wb_stb}, 32'd0);
                check("retire.valid", {31'd0, retire.valid}, 32'd0);
            end
        end
        rstn = 1'b1;
    endtask

    task automatic wait_first_fetch();
        int idle;
        idle = 0;
        while (!wb_cyc && idle < timeout_cycles) begin
            @(posedge clk);
            #1;
            idle++;
        end
        if (!wb_cyc) begin
            $display("timeout: no instruction read started within %0d cycles", timeout_cycles);
            errors++;
            timed_out = 1'b1;
        end else begin
            check("wb_stb", {31'd0, wb_stb}, 32'd1);
            check("wb_adr", wb_adr, pc_reset);
        end
    endtask

    task automatic run_program(input string name, input int n, input bit flushes);
        int          retired;
        int          idle;
        logic [31:0] r;
        retired = 0;
        idle    = 0;
        while (retired < n && idle < timeout_cycles) begin
            @(posedge clk);
            #1;
            flush = 1'b0;
            if (retire.valid) begin
                handle_retire();
                retired++;
                idle = 0;
            end else begin
                idle++;
            end
            if (flushes) begin
                r = rnd();
                if (retired >= prologue_len && r[5:0] == 6'd0) begin
                    flush    = 1'b1;
                    flush_pc = {pc_reset[31:12], r[17:8], 2'b00};
                    ref_pc   = flush_pc;    // model continues from the new pc
                    n_flush++;
                end
            end
        end
        flush = 1'b0;
        if (retired < n) begin
            $display("timeout: %s saw no retire for %0d cycles after %0d retires",
                     name, timeout_cycles, retired);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic report(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, errors - errors_at_start);
        errors_at_start = errors;
        tests++;
    endtask

    initial begin
        rstn            = 1'b0;
        flush           = 1'b0;
        flush_pc        = '0;
        rand_wait       = 1'b0;
        seed            = 32'h892e;
        errors          = 0;
        errors_at_start = 0;
        checks          = 0;
        tests           = 0;
        n_flush         = 0;
        ibar_rewrite    = 1'b0;
        timed_out       = 1'b0;

        load_program(1'b0, 1'b0);
        start_model();
        reset_dut(1'b1);
        wait_first_fetch();
        report(1, "reset state");

        if (!timed_out) begin
            seed = 32'h892e;
            load_program(1'b0, 1'b0);
            start_model();
            reset_dut(1'b0);
            run_program("alu subset", prologue_len + 200, 1'b0);
            report(2, "alu subset");
        end
        if (!timed_out) begin
            load_program(1'b1, 1'b0);
            start_model();
            reset_dut(1'b0);
            run_program("hazards", prologue_len + 200, 1'b0);
            report(3, "hazards");
        end
        if (!timed_out) begin
            load_program(1'b0, 1'b0);
            start_model();
            reset_dut(1'b0);
            run_program("flush", prologue_len + 300, 1'b1);
            $display("flush: %0d flushes applied", n_flush);
            report(4, "flush");
        end
        if (!timed_out) begin
            load_program(1'b0, 1'b1);
            start_model();
            ibar_rewrite = 1'b1;
            reset_dut(1'b0);
            run_program("ibar refetch", prologue_len + 200, 1'b0);
            ibar_rewrite = 1'b0;
            report(5, "ibar refetch");
        end
        if (!timed_out) begin
            seed = 32'h892e;    // same program as test 2
            load_program(1'b0, 1'b0);
            start_model();
            rand_wait = 1'b1;
            reset_dut(1'b0);
            run_program("wait states", prologue_len + 200, 1'b0);
            report(6, "wait states");
        end

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

/* testbench/tb_imem.sv */
`timescale 1ns/1ps

module tb_imem (
    input  logic        clk,
    input  logic        rstn,
    input  logic        rand_wait,    // 0 to 3 extra cycles per read when set
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic [31:0] wb_adr,
    output logic        wb_ack,
    output logic [31:0] wb_dat,
    output logic [31:0] mem_adr,      // word lookup hook into the bench image
    input  logic [31:0] mem_word
);

    integer     seed;
    logic       busy;
    logic [1:0] wait_cnt;

    initial seed = 32'h892e;

    assign mem_adr = wb_adr;

    function automatic logic [1:0] pick_delay();
        logic [31:0] r;
        r = $random(seed);
        return rand_wait ? r[1:0] : 2'd0;
    endfunction

    // an ack seen at this edge closes the old request, so a raised stb is not new
    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy     <= 1'b0;
            wait_cnt <= 2'd0;
            wb_ack   <= 1'b0;
            wb_dat   <= '0;
        end else begin
            wb_ack <= 1'b0;
            if (busy) begin
                if (wait_cnt == 2'd0) begin
                    busy   <= 1'b0;
                    wb_ack <= 1'b1;
                    wb_dat <= mem_word;
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end else if (wb_cyc && wb_stb && !wb_ack) begin
                busy     <= 1'b1;
                wait_cnt <= pick_delay();
            end
        end
    end

endmodule

/* hw/core_frontend_top.sv */
`timescale 1ns/1ps

module core_frontend_top import core_cfg_pkg::*, core_types_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        flush,
    input  logic [31:0] flush_pc,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic [31:0] wb_adr,
    input  logic        wb_ack,
    input  logic [31:0] wb_dat_i,
    output retire_t     retire
);

    logic [fbuf_cnt_w-1:0] buf_free;
    logic                  fetch_push;
    fetch_entry_t          fetch_data;
    logic                  bus_idle;
    logic                  redirect;
    logic [31:0]           redirect_pc;
    logic                  buf_valid;
    logic                  buf_ready;
    fetch_entry_t          buf_head;
    logic                  id_valid;
    logic                  id_ready;
    fetch_entry_t          id_entry;
    logic [4:0]            rf_raddr_a;
    logic [4:0]            rf_raddr_b;
    logic [31:0]           rf_rdata_a;
    logic [31:0]           rf_rdata_b;
    logic [4:0]            ex_rd;
    logic [4:0]            wb_pend_rd;
    logic                  ibar_done;
    uop_t                  uop;
    exec_res_t             exec_res;

    inst_fetch inst_fetch_i (
        .clk, .rstn, .flush, .flush_pc, .redirect, .redirect_pc, .buf_free,
        .wb_cyc, .wb_stb, .wb_adr, .wb_ack, .wb_dat_i,
        .fetch_push, .fetch_data, .bus_idle
    );

    fetch_buffer fetch_buffer_i (
        .clk, .rstn, .flush, .redirect, .fetch_push, .fetch_data,
        .buf_free, .buf_valid, .buf_head, .buf_ready
    );

    fifo_id_stage fifo_id_stage_i (
        .clk, .rstn, .flush, .buf_valid, .buf_head, .bus_idle, .ibar_done, .id_ready,
        .buf_ready, .id_valid, .id_entry, .redirect, .redirect_pc
    );

    inst_decode inst_decode_i (
        .clk, .rstn, .flush, .id_valid, .id_entry, .id_ready,
        .rf_raddr_a, .rf_raddr_b, .rf_rdata_a, .rf_rdata_b,
        .ex_rd, .wb_pend_rd, .uop
    );

    alu_execute alu_execute_i (
        .clk, .rstn, .flush, .uop, .exec_res, .ex_rd
    );

    writeback_regfile writeback_regfile_i (
        .clk, .rstn, .exec_res, .rf_raddr_a, .rf_raddr_b, .rf_rdata_a, .rf_rdata_b,
        .wb_pend_rd, .ibar_done, .retire
    );

endmodule

/* hw/writeback_regfile.sv */
`timescale 1ns/1ps

module writeback_regfile import core_types_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  exec_res_t   exec_res,
    input  logic [4:0]  rf_raddr_a,
    input  logic [4:0]  rf_raddr_b,
    output logic [31:0] rf_rdata_a,
    output logic [31:0] rf_rdata_b,
    output logic [4:0]  wb_pend_rd,
    output logic        ibar_done,
    output retire_t     retire
);

    logic [31:0] rf [32];
    retire_t     retire_q;
    logic        ibar_done_q;

    always_ff @(posedge clk) begin
        if (exec_res.valid && exec_res.rd != 5'd0)
            rf[exec_res.rd] <= exec_res.value;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            retire_q    <= '0;
            ibar_done_q <= 1'b0;
        end else begin
            retire_q.valid <= exec_res.valid;
            retire_q.pc    <= exec_res.pc;
            retire_q.rd    <= exec_res.rd;
            retire_q.value <= exec_res.value;
            ibar_done_q    <= exec_res.valid && exec_res.is_ibar;    // one-cycle pulse
        end
    end

    // r0 is hardwired
    assign rf_rdata_a = (rf_raddr_a == 5'd0) ? '0 : rf[rf_raddr_a];
    assign rf_rdata_b = (rf_raddr_b == 5'd0) ? '0 : rf[rf_raddr_b];

    assign wb_pend_rd = exec_res.valid ? exec_res.rd : 5'd0;    // lands at the next edge
    assign ibar_done  = ibar_done_q;
    assign retire     = retire_q;

endmodule

/* hw/alu_execute.sv */
`timescale 1ns/1ps

module alu_execute import core_types_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      flush,
    input  uop_t      uop,
    output exec_res_t exec_res,
    output logic [4:0] ex_rd
);

    exec_res_t   res_q;
    logic [31:0] value;

    always_comb begin
        case (uop.alu_op)
            add:     value = uop.src_a + uop.src_b;    // wraps at 32 bits
            sub:     value = uop.src_a - uop.src_b;
            and_op:  value = uop.src_a & uop.src_b;
            or_op:   value = uop.src_a | uop.src_b;
            xor_op:  value = uop.src_a ^ uop.src_b;
            default: value = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            res_q <= '0;
        else if (flush)
            res_q <= '0;
        else begin
            res_q.valid   <= uop.valid;
            res_q.pc      <= uop.pc;
            res_q.rd      <= uop.rd;
            res_q.value   <= value;
            res_q.is_ibar <= uop.is_ibar;
        end
    end

    // the result still on the output during a flush belongs to the old stream
    always_comb begin
        exec_res       = res_q;
        exec_res.valid = res_q.valid && !flush;
    end

    assign ex_rd = res_q.valid ? res_q.rd : 5'd0;

    // immediates only come from addi.w, andi and ori
    a_imm_ops: assert property (@(posedge clk) disable iff (!rstn)
        uop.valid && uop.is_imm |-> uop.alu_op inside {add, and_op, or_op});

endmodule

/* hw/inst_decode.sv */
`timescale 1ns/1ps

module inst_decode import core_cfg_pkg::*, core_types_pkg::*; (
    input  logic         clk,
    input  logic         rstn,
    input  logic         flush,
    input  logic         id_valid,
    input  fetch_entry_t id_entry,
    output logic         id_ready,
    output logic [4:0]   rf_raddr_a,
    output logic [4:0]   rf_raddr_b,
    input  logic [31:0]  rf_rdata_a,
    input  logic [31:0]  rf_rdata_b,
    input  logic [4:0]   ex_rd,
    input  logic [4:0]   wb_pend_rd,
    output uop_t         uop
);

    inst_u       inst;
    alu_op_e     dec_op;
    logic [4:0]  dec_rd;
    logic [31:0] dec_imm;
    logic        dec_r3;
    logic        dec_imm_en;
    logic        dec_ibar;
    logic        hazard;

    assign inst = id_entry.inst;

    function automatic logic busy(input logic [4:0] r);
        return (r != 5'd0) &&
               ((uop.valid && uop.rd == r) || ex_rd == r || wb_pend_rd == r);
    endfunction

    always_comb begin
        dec_op     = add;
        dec_rd     = 5'd0;
        dec_imm    = '0;
        dec_r3     = 1'b1;
        dec_imm_en = 1'b0;
        dec_ibar   = 1'b0;
        rf_raddr_a = 5'd0;
        rf_raddr_b = 5'd0;
        case (inst.r3.opcode)
            op_add_w: dec_op = add;
            op_sub_w: dec_op = sub;
            op_and:   dec_op = and_op;
            op_or:    dec_op = or_op;
            op_xor:   dec_op = xor_op;
            op_ibar:  dec_ibar = 1'b1;    // travels as add r0 = 0 + 0
            default:  dec_r3 = 1'b0;
        endcase
        if (dec_r3 && !dec_ibar) begin
            rf_raddr_a = inst.r3.rj;
            rf_raddr_b = inst.r3.rk;
            dec_rd     = inst.r3.rd;
        end
        if (!dec_r3) begin
            dec_imm_en = 1'b1;
            case (inst.ri12.opcode)
                op_addi_w: dec_imm = {{20{inst.ri12.imm[11]}}, inst.ri12.imm};
                op_andi: begin
                    dec_op  = and_op;
                    dec_imm = {20'd0, inst.ri12.imm};
                end
                op_ori: begin
                    dec_op  = or_op;
                    dec_imm = {20'd0, inst.ri12.imm};
                end
                default: dec_imm_en = 1'b0;    // unknown word retires as a nop
            endcase
            if (dec_imm_en) begin
                rf_raddr_a = inst.ri12.rj;
                dec_rd     = inst.ri12.rd;
            end
        end
    end

    // no forwarding, wait until every producer has written the file
    always_comb begin
        hazard = busy(rf_raddr_a) || busy(rf_raddr_b);
    end

    assign id_ready = !(id_valid && hazard);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            uop <= '0;
        else if (flush)
            uop <= '0;
        else begin
            uop.valid   <= id_valid && !hazard;
            uop.pc      <= id_entry.pc;
            uop.alu_op  <= dec_op;
            uop.rd      <= dec_rd;
            uop.src_a   <= rf_rdata_a;
            uop.src_b   <= dec_imm_en ? dec_imm : rf_rdata_b;
            uop.is_ibar <= dec_ibar;
            uop.is_imm  <= dec_imm_en;
        end
    end

    a_uop_op_known: assert property (@(posedge clk) disable iff (!rstn)
        uop.valid |-> !$isunknown(uop.alu_op) &&
            uop.alu_op inside {add, sub, and_op, or_op, xor_op});

endmodule

/* hw/fifo_id_stage.sv */
`timescale 1ns/1ps

module fifo_id_stage import core_cfg_pkg::*, core_types_pkg::*; (
    input  logic         clk,
    input  logic         rstn,
    input  logic         flush,
    input  logic         buf_valid,
    input  fetch_entry_t buf_head,
    input  logic         bus_idle,
    input  logic         ibar_done,
    input  logic         id_ready,
    output logic         buf_ready,
    output logic         id_valid,
    output fetch_entry_t id_entry,
    output logic         redirect,
    output logic [31:0]  redirect_pc
);

    typedef enum logic [1:0] {
        idle,
        wait_ex_ibar,
        wait_bus_idle,
        wait_fetch
    } id_state_e;

    id_state_e    state;
    fetch_entry_t id_q;
    logic         id_vq;
    logic [31:0]  ibar_pc_q;
    logic         cur_ibar;
    logic         take;
    logic         ibar_go;

    assign cur_ibar = (id_q.inst.r3.opcode == op_ibar);
    assign ibar_go  = (state == idle) && id_vq && cur_ibar && id_ready;

    // nothing new comes in behind an ibar
    assign buf_ready = (state == idle) && (!id_vq || (id_ready && !cur_ibar));
    assign take      = buf_valid && buf_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            id_q  <= '{pc: pc_reset, inst: inst_nop};
            id_vq <= 1'b0;
        end else if (flush) begin
            id_q.inst <= inst_nop;
            id_vq     <= 1'b0;
        end else if (take) begin
            id_q  <= buf_head;
            id_vq <= 1'b1;
        end else if (!id_vq || id_ready) begin
            id_q.inst <= inst_nop;    // drained, keep a bubble in place
            id_vq     <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            state <= idle;
        else if (flush)
            state <= idle;
        else begin
            case (state)
                idle:          if (ibar_go) state <= wait_ex_ibar;
                wait_ex_ibar:  if (ibar_done) state <= wait_bus_idle;
                wait_bus_idle: if (bus_idle) state <= wait_fetch;
                wait_fetch:    if (buf_valid) state <= idle;
                default:       state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ibar_go)
            ibar_pc_q <= id_q.pc;
    end

    assign id_valid    = id_vq;
    assign id_entry    = id_q;
    assign redirect    = (state == wait_bus_idle) && bus_idle;
    assign redirect_pc = ibar_pc_q + 32'd4;    // refetch everything after the barrier

endmodule

/* hw/fetch_buffer.sv */
`timescale 1ns/1ps

module fetch_buffer import core_cfg_pkg::*, core_types_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  flush,
    input  logic                  redirect,
    input  logic                  fetch_push,
    input  fetch_entry_t          fetch_data,
    output logic [fbuf_cnt_w-1:0] buf_free,
    output logic                  buf_valid,
    output fetch_entry_t          buf_head,
    input  logic                  buf_ready
);

    fetch_entry_t          mem [fbuf_depth];
    logic [fbuf_ptr_w-1:0] rd_ptr;
    logic [fbuf_ptr_w-1:0] wr_ptr;
    logic [fbuf_cnt_w-1:0] count;
    logic                  pop;

    assign pop = buf_valid && buf_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush || redirect) begin
            rd_ptr <= '0;    // whole queue is stale
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (fetch_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (fetch_push && !pop)
                count <= count + 1'b1;
            else if (pop && !fetch_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_push)
            mem[wr_ptr] <= fetch_data;
    end

    assign buf_valid = (count != '0);
    assign buf_head  = mem[rd_ptr];
    assign buf_free  = fbuf_cnt_w'(fbuf_depth) - count;

    // fetch must have reserved the slot before the ack came back
    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        fetch_push |-> count < fbuf_cnt_w'(fbuf_depth));

endmodule

/* hw/inst_fetch.sv */
`timescale 1ns/1ps

module inst_fetch import core_cfg_pkg::*, core_types_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  flush,
    input  logic [31:0]           flush_pc,
    input  logic                  redirect,
    input  logic [31:0]           redirect_pc,
    input  logic [fbuf_cnt_w-1:0] buf_free,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic [31:0]           wb_adr,
    input  logic                  wb_ack,
    input  logic [31:0]           wb_dat_i,
    output logic                  fetch_push,
    output fetch_entry_t          fetch_data,
    output logic                  bus_idle
);

    logic                  cyc_q;
    logic                  drop_q;    // open cycle belongs to a stale stream
    logic [31:0]           pc_q;      // next address to fetch
    logic [31:0]           adr_q;     // address of the open cycle
    logic                  ack;
    logic                  restart;
    logic [31:0]           restart_pc;
    logic                  start;
    logic [fbuf_cnt_w-1:0] need;

    assign ack        = cyc_q && wb_ack;
    assign restart    = flush || redirect;
    assign restart_pc = flush ? flush_pc : redirect_pc;

    // a word landing this cycle takes a slot too, so back-to-back needs two
    assign need  = (ack && !drop_q) ? fbuf_cnt_w'(2) : fbuf_cnt_w'(1);
    assign start = !restart && (!cyc_q || ack) && (buf_free >= need);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cyc_q  <= 1'b0;
            drop_q <= 1'b0;
            pc_q   <= pc_reset;
            adr_q  <= pc_reset;
        end else begin
            if (ack) begin
                cyc_q  <= 1'b0;
                drop_q <= 1'b0;
            end
            if (restart) begin
                pc_q <= restart_pc;
                if (cyc_q && !wb_ack)
                    drop_q <= 1'b1;    // let the slave finish, discard its data
            end else if (start) begin
                cyc_q <= 1'b1;
                adr_q <= pc_q;
                pc_q  <= pc_q + 32'd4;
            end
        end
    end

    assign wb_cyc   = cyc_q;
    assign wb_stb   = cyc_q;
    assign wb_adr   = adr_q;
    assign bus_idle = !cyc_q;

    assign fetch_push      = ack && !drop_q && !restart;
    assign fetch_data.pc   = adr_q;
    assign fetch_data.inst = wb_dat_i;

    // classic rule: request and address hold until the slave acks
    a_wb_hold: assert property (@(posedge clk) disable iff (!rstn)
        wb_stb && !wb_ack |=> wb_stb && wb_cyc && $stable(wb_adr));

endmodule

/* hw/core_types_pkg.sv */
package core_types_pkg;

    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } r3_view_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } ri12_view_t;

    // one instruction word seen through both formats
    typedef union packed {
        r3_view_t   r3;
        ri12_view_t ri12;
    } inst_u;

    typedef enum logic [2:0] {
        add,
        sub,
        and_op,
        or_op,
        xor_op
    } alu_op_e;

    typedef struct packed {
        logic [31:0] pc;
        inst_u       inst;
    } fetch_entry_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        alu_op_e     alu_op;
        logic [4:0]  rd;
        logic [31:0] src_a;
        logic [31:0] src_b;   // register or extended immediate
        logic        is_ibar;
        logic        is_imm;
    } uop_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] value;
        logic        is_ibar;
    } exec_res_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] value;
    } retire_t;

endpackage

/* hw/core_cfg_pkg.sv */
package core_cfg_pkg;

    // boot address of the core
    localparam logic [31:0] pc_reset = 32'h1c00_0000;

    // andi r0,r0,0
    localparam logic [31:0] inst_nop = 32'h0340_0000;

    // 3R opcodes, inst[31:15]
    localparam logic [16:0] op_add_w = 17'h00020;
    localparam logic [16:0] op_sub_w = 17'h00022;
    localparam logic [16:0] op_and   = 17'h00029;
    localparam logic [16:0] op_or    = 17'h0002a;
    localparam logic [16:0] op_xor   = 17'h0002b;

    // barrier shares the 3R opcode field, hint sits in the low bits
    localparam logic [16:0] op_ibar  = 17'h070e5;

    // 2RI12 opcodes, inst[31:22]
    localparam logic [9:0]  op_addi_w = 10'h00a;
    localparam logic [9:0]  op_andi   = 10'h00d;
    localparam logic [9:0]  op_ori    = 10'h00e;

    // fetch buffer, depth must stay a power of two for pointer wrap
    localparam int fbuf_depth = 4;
    localparam int fbuf_ptr_w = $clog2(fbuf_depth);
    localparam int fbuf_cnt_w = $clog2(fbuf_depth + 1);

endpackage
